// File: logic/core_cfg_pkg.sv
package core_cfg_pkg;

  // machine word and register index widths
  localparam int xlen         = 64;
  localparam int reg_id_width = 5;

  // first fetch address out of reset
  localparam logic [xlen-1:0] reset_pc = 64'h0000_0000_8000_0000;

  // data-memory request, one per cycle, answered in the same cycle
  typedef struct packed {
    logic            wen;
    logic            ren;
    logic [xlen-1:0] addr;
    // already shifted onto the addressed byte lanes
    logic [xlen-1:0] wdata;
    // one bit per byte lane
    logic [7:0]      wmask;
  } dmem_req_t;

  // retire record, valid once per executed instruction
  typedef struct packed {
    logic                    valid;
    logic [xlen-1:0]         pc;
    logic [reg_id_width-1:0] rd;
    logic                    wen;
    logic [xlen-1:0]         wdata;
  } commit_t;

endpackage

// File: logic/rv_isa_pkg.sv
package rv_isa_pkg;

  // major opcodes, inst[6:0]
  typedef enum logic [6:0] {
    op_lui    = 7'b0110111,
    op_auipc  = 7'b0010111,
    op_jal    = 7'b1101111,
    op_jalr   = 7'b1100111,
    op_branch = 7'b1100011,
    op_load   = 7'b0000011,
    op_store  = 7'b0100011,
    op_imm    = 7'b0010011,
    op_reg    = 7'b0110011,
    op_system = 7'b1110011
  } opcode_e;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt
  } alu_op_e;

  typedef enum logic [1:0] {
    st_run,
    st_halted,
    st_trapped
  } core_state_e;

  // encoded like funct3[1:0] of loads and stores
  typedef enum logic [1:0] {
    sz_byte  = 2'b00,
    sz_word  = 2'b10,
    sz_dword = 2'b11
  } mem_size_e;

  // the only system encoding accepted
  localparam logic [31:0] ebreak_inst = 32'h0010_0073;

  typedef struct packed {
    logic [core_cfg_pkg::reg_id_width-1:0] rd;
    logic [core_cfg_pkg::reg_id_width-1:0] rs1;
    logic [core_cfg_pkg::reg_id_width-1:0] rs2;
    // sign-extended for every format
    logic [core_cfg_pkg::xlen-1:0]         imm;
    alu_op_e                               alu_op;
    // operand b is imm, operand a is pc
    logic                                  use_imm;
    logic                                  use_pc;
    logic                                  reg_wen;
    logic                                  is_load;
    logic                                  is_store;
    mem_size_e                             mem_size;
    logic                                  is_jal;
    logic                                  is_jalr;
    logic                                  is_branch;
    // bne rather than beq
    logic                                  branch_ne;
    logic                                  is_ebreak;
    logic                                  illegal;
  } decoded_t;

endpackage

// File: logic/inst_decoder.sv
`timescale 1ns/100ps

module inst_decoder import core_cfg_pkg::*, rv_isa_pkg::*; (
  input  logic [31:0] inst,
  output decoded_t    dec
);

  opcode_e         opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_s;
  logic [xlen-1:0] imm_b;
  logic [xlen-1:0] imm_u;
  logic [xlen-1:0] imm_j;

  assign opcode = opcode_e'(inst[6:0]);
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  // immediates per format, all sign-extended from inst[31]
  assign imm_i = {{(xlen-12){inst[31]}}, inst[31:20]};
  assign imm_s = {{(xlen-12){inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{(xlen-12){inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {{(xlen-32){inst[31]}}, inst[31:12], 12'b0};
  assign imm_j = {{(xlen-20){inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    dec          = '0;
    dec.rd       = inst[11:7];
    dec.rs1      = inst[19:15];
    dec.rs2      = inst[24:20];
    dec.alu_op   = alu_add;
    dec.mem_size = sz_dword;
    case (opcode)
      op_lui: begin
        // rs1 field is immediate here, force x0 so alu gives imm
        dec.rs1     = '0;
        dec.imm     = imm_u;
        dec.use_imm = 1'b1;
        dec.reg_wen = 1'b1;
      end
      op_auipc: begin
        dec.imm     = imm_u;
        dec.use_imm = 1'b1;
        dec.use_pc  = 1'b1;
        dec.reg_wen = 1'b1;
      end
      op_jal: begin
        dec.imm     = imm_j;
        dec.is_jal  = 1'b1;
        dec.reg_wen = 1'b1;
      end
      op_jalr: begin
        // alu forms rs1+imm, pc unit clears bit 0
        dec.imm     = imm_i;
        dec.use_imm = 1'b1;
        dec.is_jalr = 1'b1;
        dec.reg_wen = 1'b1;
        dec.illegal = (funct3 != 3'b000);
      end
      op_branch: begin
        dec.imm       = imm_b;
        dec.is_branch = 1'b1;
        dec.branch_ne = funct3[0];
        // beq and bne only
        dec.illegal   = (funct3[2:1] != 2'b00);
      end
      op_load: begin
        dec.imm      = imm_i;
        dec.use_imm  = 1'b1;
        dec.is_load  = 1'b1;
        dec.reg_wen  = 1'b1;
        dec.mem_size = mem_size_e'(funct3[1:0]);
        // lb, lw, ld
        dec.illegal  = !(funct3 inside {3'b000, 3'b010, 3'b011});
      end
      op_store: begin
        dec.imm      = imm_s;
        dec.use_imm  = 1'b1;
        dec.is_store = 1'b1;
        dec.mem_size = mem_size_e'(funct3[1:0]);
        dec.illegal  = !(funct3 inside {3'b000, 3'b010, 3'b011});
      end
      op_imm: begin
        // addi only
        dec.imm     = imm_i;
        dec.use_imm = 1'b1;
        dec.reg_wen = 1'b1;
        dec.illegal = (funct3 != 3'b000);
      end
      op_reg: begin
        dec.reg_wen = 1'b1;
        case ({funct7, funct3})
          {7'b0000000, 3'b000}: dec.alu_op = alu_add;
          {7'b0100000, 3'b000}: dec.alu_op = alu_sub;
          {7'b0000000, 3'b111}: dec.alu_op = alu_and;
          {7'b0000000, 3'b110}: dec.alu_op = alu_or;
          {7'b0000000, 3'b100}: dec.alu_op = alu_xor;
          {7'b0000000, 3'b010}: dec.alu_op = alu_slt;
          default:              dec.illegal = 1'b1;
        endcase
      end
      op_system: begin
        // ebreak is the only system instruction kept
        dec.is_ebreak = (inst == ebreak_inst);
        dec.illegal   = (inst != ebreak_inst);
      end
      default: dec.illegal = 1'b1;
    endcase
    // unknown encodings must not change architectural state
    if (dec.illegal) begin
      dec.reg_wen  = 1'b0;
      dec.is_store = 1'b0;
      dec.is_load  = 1'b0;
    end
  end

endmodule

// File: logic/reg_file.sv
`timescale 1ns/100ps

module reg_file import core_cfg_pkg::*; (
  input  logic                    clk,
  input  logic [reg_id_width-1:0] rs1,
  input  logic [reg_id_width-1:0] rs2,
  output logic [xlen-1:0]         rdata_1,
  output logic [xlen-1:0]         rdata_2,
  input  logic [reg_id_width-1:0] rd,
  input  logic                    wen,
  input  logic [xlen-1:0]         wdata
);

  // x1..x31, x0 has no storage
  logic [xlen-1:0] regs [1:31];

  // write at the edge that ends the cycle
  always_ff @(posedge clk) begin
    if (wen && rd != '0) begin
      regs[rd] <= wdata;
    end
  end

  // combinational reads, x0 reads zero
  always_comb begin
    rdata_1 = '0;
    rdata_2 = '0;
    if (rs1 != '0) begin
      rdata_1 = regs[rs1];
    end
    if (rs2 != '0) begin
      rdata_2 = regs[rs2];
    end
  end

endmodule

// File: logic/alu.sv
`timescale 1ns/100ps

module alu import core_cfg_pkg::*, rv_isa_pkg::*; (
  input  logic [xlen-1:0] operand_a,
  input  logic [xlen-1:0] operand_b,
  input  alu_op_e         op,
  output logic [xlen-1:0] result
);

  // signed compare result, 0 or 1
  logic less_signed;

  assign less_signed = $signed(operand_a) < $signed(operand_b);

  always_comb begin
    case (op)
      alu_add: result = operand_a + operand_b;
      alu_sub: result = operand_a - operand_b;
      alu_and: result = operand_a & operand_b;
      alu_or:  result = operand_a | operand_b;
      alu_xor: result = operand_a ^ operand_b;
      alu_slt: result = {{(xlen-1){1'b0}}, less_signed};
      // unused encodings fall back to add
      default: result = operand_a + operand_b;
    endcase
  end

endmodule

// File: logic/pc_unit.sv
`timescale 1ns/100ps

module pc_unit import core_cfg_pkg::*, rv_isa_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  decoded_t        dec,
  input  logic [xlen-1:0] rdata_1,
  input  logic [xlen-1:0] rdata_2,
  input  logic [xlen-1:0] alu_result,
  output logic [xlen-1:0] pc,
  output logic            running,
  output core_state_e     state
);

  logic [xlen-1:0] pc_plus4;
  logic [xlen-1:0] rel_target;
  logic [xlen-1:0] next_pc;
  logic            taken;
  // low through reset, so nothing retires while rst_n is held
  logic            started;

  assign pc_plus4   = pc + 64'd4;
  // shared by branches and jal
  assign rel_target = pc + dec.imm;
  // beq takes on equal, bne on not equal
  assign taken      = dec.is_branch && ((rdata_1 == rdata_2) ^ dec.branch_ne);
  assign running    = started && (state == st_run);

  always_comb begin
    if (dec.is_jalr) begin
      next_pc = {alu_result[xlen-1:1], 1'b0};
    end else if (dec.is_jal || taken) begin
      next_pc = rel_target;
    end else begin
      next_pc = pc_plus4;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc      <= reset_pc;
      state   <= st_run;
      started <= 1'b0;
    end else begin
      started <= 1'b1;
      // pc freezes on the stopping instruction itself
      if (running) begin
        if (dec.illegal) begin
          state <= st_trapped;
        end else if (dec.is_ebreak) begin
          state <= st_halted;
        end else begin
          pc <= next_pc;
        end
      end
    end
  end

endmodule

// File: logic/lsu.sv
`timescale 1ns/100ps

module lsu import core_cfg_pkg::*, rv_isa_pkg::*; (
  input  decoded_t        dec,
  input  logic            running,
  input  logic [xlen-1:0] addr,
  input  logic [xlen-1:0] store_data,
  output dmem_req_t       dmem_req,
  input  logic [xlen-1:0] dmem_rdata,
  output logic [xlen-1:0] load_data
);

  // byte lane of the access inside the 64-bit word
  logic [2:0]      lane;
  logic [5:0]      shamt;
  logic [7:0]      size_mask;
  logic [xlen-1:0] lane_data;

  assign lane  = addr[2:0];
  assign shamt = {lane, 3'b000};

  // lanes covered by one access, before placement
  always_comb begin
    case (dec.mem_size)
      sz_byte: size_mask = 8'h01;
      sz_word: size_mask = 8'h0f;
      default: size_mask = 8'hff;
    endcase
  end

  always_comb begin
    dmem_req.wen   = running && dec.is_store;
    dmem_req.ren   = running && dec.is_load;
    dmem_req.addr  = addr;
    // aligned access, so the shift never spills out of the word
    dmem_req.wdata = store_data << shamt;
    dmem_req.wmask = '0;
    if (dmem_req.wen) begin
      dmem_req.wmask = size_mask << lane;
    end
  end

  // addressed lanes moved down to bit 0
  assign lane_data = dmem_rdata >> shamt;

  // sign extension per size
  always_comb begin
    case (dec.mem_size)
      sz_byte: load_data = {{(xlen-8){lane_data[7]}}, lane_data[7:0]};
      sz_word: load_data = {{(xlen-32){lane_data[31]}}, lane_data[31:0]};
      default: load_data = lane_data;
    endcase
  end

endmodule

// File: logic/rv_core.sv
`timescale 1ns/100ps

module rv_core import core_cfg_pkg::*, rv_isa_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  output logic [xlen-1:0] pc,
  input  logic [31:0]     inst,
  output dmem_req_t       dmem_req,
  input  logic [xlen-1:0] dmem_rdata,
  output commit_t         commit,
  output logic            halted,
  output logic            trapped
);

  decoded_t        dec;
  logic [xlen-1:0] rdata_1;
  logic [xlen-1:0] rdata_2;
  logic [xlen-1:0] operand_a;
  logic [xlen-1:0] operand_b;
  logic [xlen-1:0] alu_result;
  logic [xlen-1:0] load_data;
  logic [xlen-1:0] link_addr;
  logic [xlen-1:0] wb_data;
  logic            running;
  logic            retire;
  logic            rf_wen;
  core_state_e     state;

  inst_decoder u_inst_decoder (
    .inst (inst),
    .dec  (dec)
  );

  reg_file u_reg_file (
    .clk     (clk),
    .rs1     (dec.rs1),
    .rs2     (dec.rs2),
    .rdata_1 (rdata_1),
    .rdata_2 (rdata_2),
    .rd      (dec.rd),
    .wen     (rf_wen),
    .wdata   (wb_data)
  );

  // operand select, pc for auipc, imm for i/s/u formats
  assign operand_a = dec.use_pc ? pc : rdata_1;
  assign operand_b = dec.use_imm ? dec.imm : rdata_2;

  alu u_alu (
    .operand_a (operand_a),
    .operand_b (operand_b),
    .op        (dec.alu_op),
    .result    (alu_result)
  );

  pc_unit u_pc_unit (
    .clk        (clk),
    .rst_n      (rst_n),
    .dec        (dec),
    .rdata_1    (rdata_1),
    .rdata_2    (rdata_2),
    .alu_result (alu_result),
    .pc         (pc),
    .running    (running),
    .state      (state)
  );

  // address from the alu, store data straight from rs2
  lsu u_lsu (
    .dec        (dec),
    .running    (running),
    .addr       (alu_result),
    .store_data (rdata_2),
    .dmem_req   (dmem_req),
    .dmem_rdata (dmem_rdata),
    .load_data  (load_data)
  );

  // return address of jal and jalr
  assign link_addr = pc + 64'd4;

  always_comb begin
    if (dec.is_jal || dec.is_jalr) begin
      wb_data = link_addr;
    end else if (dec.is_load) begin
      wb_data = load_data;
    end else begin
      wb_data = alu_result;
    end
  end

  // ebreak and illegal words stop the core without retiring
  assign retire = running && !dec.illegal && !dec.is_ebreak;
  assign rf_wen = retire && dec.reg_wen;

  always_comb begin
    commit.valid = retire;
    commit.pc    = pc;
    commit.rd    = dec.rd;
    commit.wen   = rf_wen;
    commit.wdata = wb_data;
  end

  assign halted  = (state == st_halted);
  assign trapped = (state == st_trapped);

endmodule

// File: verification/core_checker.sv
`timescale 1ns/100ps

module core_checker import core_cfg_pkg::*; (
  input logic            clk,
  input logic            rst_n,
  input logic [xlen-1:0] pc,
  input dmem_req_t       dmem_req,
  input logic            halted,
  input logic            trapped
);

  // one data access per cycle, read or write
  no_read_write: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(dmem_req.wen && dmem_req.ren)
  ) else $error("data request drives wen and ren together");

  // byte lanes only enabled for a store
  mask_idle: assert property (
    @(posedge clk) disable iff (!rst_n)
    !dmem_req.wen |-> (dmem_req.wmask == '0)
  ) else $error("wmask set without wen");

  // the two stop states exclude each other
  one_stop_state: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(halted && trapped)
  ) else $error("halted and trapped both set");

  // stopped core keeps its pc until reset
  pc_frozen: assert property (
    @(posedge clk) disable iff (!rst_n)
    (halted || trapped) |=> $stable(pc)
  ) else $error("pc moved after the core stopped");

endmodule

// File: verification/core_tb.sv
`timescale 1ns/100ps

module core_tb
  import core_cfg_pkg::*, rv_isa_pkg::*;
();

  localparam int prog_len      = 256;
  localparam int reset_cycles  = 16;
  localparam int freeze_cycles = 8;
  localparam int dmem_words    = 256;
  localparam int timeout_limit = 4 * prog_len + reset_cycles;
  // slot 31 follows the straight-line register setup so it is always reached
  localparam int illegal_slot  = 31;
  localparam logic [31:0] illegal_word = 32'hffff_ffff;

  logic            clk;
  logic            rst_n;
  logic [xlen-1:0] pc;
  logic [31:0]     inst;
  dmem_req_t       dmem_req;
  logic [xlen-1:0] dmem_rdata;
  commit_t         commit;
  logic            halted;
  logic            trapped;

  logic [31:0]     imem [prog_len];
  logic [63:0]     dmem [dmem_words];
  logic            dmem_ready = 1'b0;
  logic [63:0]     pc_off;
  // model state
  logic [63:0]     m_regs [32];
  logic [63:0]     m_mem [dmem_words];
  logic [63:0]     m_pc;
  logic [31:0]     lfsr_state;
  int              errors;
  int              checks;
  int              cycles;

  rv_core dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .pc         (pc),
    .inst       (inst),
    .dmem_req   (dmem_req),
    .dmem_rdata (dmem_rdata),
    .commit     (commit),
    .halted     (halted),
    .trapped    (trapped)
  );

  bind rv_core core_checker u_core_checker (
    .clk      (clk),
    .rst_n    (rst_n),
    .pc       (pc),
    .dmem_req (dmem_req),
    .halted   (halted),
    .trapped  (trapped)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // combinational fetch that reads as illegal outside the program
  assign pc_off     = pc - reset_pc;
  assign inst       = (pc_off < 64'd1024) ? imem[pc_off[9:2]] : illegal_word;
  assign dmem_rdata = dmem[dmem_req.addr[10:3]];

  // fill pattern depends on the whole word index
  function automatic logic [63:0] fill_word(input int i);
    return {32'(i) * 32'h9e37_79b9, ~32'(i) ^ 32'h5a5a_0f0f};
  endfunction

  // data memory is filled once and then written per byte lane at the edge
  always @(posedge clk) begin
    if (!dmem_ready) begin
      for (int i = 0; i < dmem_words; i++) begin
        dmem[i] <= fill_word(i);
      end
      dmem_ready <= 1'b1;
    end else if (dmem_req.wen) begin
      for (int b = 0; b < 8; b++) begin
        if (dmem_req.wmask[b]) begin
          dmem[dmem_req.addr[10:3]][8*b +: 8] <= dmem_req.wdata[8*b +: 8];
        end
      end
    end
  end

  // cycle limit that restarts with every reset
  always @(posedge clk) begin
    if (!rst_n) begin
      cycles <= 0;
    end else begin
      cycles <= cycles + 1;
      if (cycles >= timeout_limit) begin
        $display("timeout: the core did not stop within %0d cycles", timeout_limit);
        $display("Result: FAILED");
        $finish;
      end
    end
  end

  // fibonacci lfsr with taps 32 22 2 1 stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int k = 0; k < n; k++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // instruction encoders
  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [2:0] f3);
    return {imm[11:5], rs2, 5'd0, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  // forward target that never hits the addi or jalr of a jump triple
  function automatic int fwd_target(input int slot);
    int t;
    t = slot + 1 + int'(rand_bits(3));
    if (t >= 32 && t < 240 && t % 16 >= 14) begin
      t = t - t % 16 + 13;
    end
    if (t > prog_len - 1) begin
      t = prog_len - 1;
    end
    return t;
  endfunction

  function automatic logic [31:0] random_inst(input int slot);
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  kind;
    logic [2:0]  f3;
    logic [11:0] off;
    logic [1:0]  sz;
    int          sel;
    kind = 3'(rand_bits(3));
    rd   = 5'(rand_bits(5));
    rs1  = 5'(rand_bits(3));
    rs2  = 5'(rand_bits(3));
    // size-aligned offset in the 2 KB window
    sz   = 2'(rand_bits(2));
    f3   = (sz == 2'd0) ? 3'b000 : (sz == 2'd1) ? 3'b010 : 3'b011;
    off  = {1'b0, 11'(rand_bits(11))};
    if (f3 == 3'b010) off[1:0] = 2'b00;
    if (f3 == 3'b011) off[2:0] = 3'b000;
    case (kind)
      3'd0: return {20'(rand_bits(20)), rd, 7'b0110111};
      3'd1: return {20'(rand_bits(20)), rd, 7'b0010111};
      3'd2: return enc_i(12'(rand_bits(12)), rs1, 3'b000, rd, 7'b0010011);
      3'd3: begin
        sel = int'(rand_bits(3)) % 6;
        case (sel)
          0: return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
          1: return {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
          2: return {7'b0000000, rs2, rs1, 3'b111, rd, 7'b0110011};
          3: return {7'b0000000, rs2, rs1, 3'b110, rd, 7'b0110011};
          4: return {7'b0000000, rs2, rs1, 3'b100, rd, 7'b0110011};
          default: return {7'b0000000, rs2, rs1, 3'b010, rd, 7'b0110011};
        endcase
      end
      3'd4: begin
        // equal operands half the time so both outcomes show up
        if (rand_bits(1) == 32'd1) rs2 = rs1;
        f3 = {2'b00, 1'(rand_bits(1))};
        return enc_b(13'((fwd_target(slot) - slot) * 4), rs2, rs1, f3);
      end
      3'd5: return enc_j(21'((fwd_target(slot) - slot) * 4), rd);
      3'd6: return enc_i(off, 5'd0, f3, rd, 7'b0000011);
      default: return enc_s(off, rs2, f3);
    endcase
  endfunction

  task automatic build_program();
    int t;
    for (int s = 0; s < prog_len; s++) begin
      if (s == prog_len - 1) begin
        imem[s] = 32'h0010_0073;
      end else if (s < 31) begin
        // known value in every register first
        imem[s] = enc_i(12'(rand_bits(12)), 5'd0, 3'b000, 5'(s + 1), 7'b0010011);
      end else if (s >= 32 && s < 240 && s % 16 == 13) begin
        imem[s] = {20'd0, 5'd31, 7'b0010111};
      end else if (s >= 32 && s < 240 && s % 16 == 14) begin
        // offset from the auipc slot into the next block
        t = (s / 16 + 1) * 16 + int'(rand_bits(3));
        imem[s] = enc_i(12'((t - (s - 1)) * 4), 5'd31, 3'b000, 5'd31, 7'b0010011);
      end else if (s >= 32 && s < 240 && s % 16 == 15) begin
        // imm of 1 checks that bit 0 of the target is cleared
        imem[s] = enc_i(12'd1, 5'd31, 3'b000, 5'(rand_bits(5)), 7'b1100111);
      end else begin
        imem[s] = random_inst(s);
      end
    end
  endtask

  // model executes the instruction at m_pc and checks the retire
  task automatic model_retire();
    logic [63:0] off;
    logic [31:0] w;
    logic [2:0]  f3;
    logic [63:0] rs1v;
    logic [63:0] rs2v;
    logic [63:0] imm_i;
    logic [63:0] imm_s;
    logic [63:0] wd;
    logic [63:0] npc;
    logic [63:0] addr;
    logic [63:0] data;
    logic [63:0] lanes;
    logic [7:0]  mask;
    logic [5:0]  sh;
    logic        wen;
    logic        is_ld;
    logic        is_st;
    off = m_pc - reset_pc;
    w = imem[off[9:2]];
    f3 = w[14:12];
    rs1v = m_regs[w[19:15]];
    rs2v = m_regs[w[24:20]];
    imm_i = {{52{w[31]}}, w[31:20]};
    imm_s = {{52{w[31]}}, w[31:25], w[11:7]};
    addr = rs1v + ((w[6:0] == 7'b0100011) ? imm_s : imm_i);
    sh = {addr[2:0], 3'b000};
    npc = m_pc + 64'd4;
    wd = '0;
    wen = 1'b1;
    is_ld = 1'b0;
    is_st = 1'b0;
    check_value("commit.pc", commit.pc, m_pc);
    case (w[6:0])
      7'b0110111: wd = {{32{w[31]}}, w[31:12], 12'h000};
      7'b0010111: wd = m_pc + {{32{w[31]}}, w[31:12], 12'h000};
      7'b1101111: begin
        wd = m_pc + 64'd4;
        npc = m_pc + {{44{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      end
      7'b1100111: begin
        wd = m_pc + 64'd4;
        npc = (rs1v + imm_i) & ~64'd1;
      end
      7'b1100011: begin
        wen = 1'b0;
        if ((rs1v == rs2v) != f3[0]) begin
          npc = m_pc + {{52{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        end
      end
      7'b0000011: begin
        is_ld = 1'b1;
        data = m_mem[addr[10:3]] >> sh;
        if (f3 == 3'b000) wd = {{56{data[7]}}, data[7:0]};
        else if (f3 == 3'b010) wd = {{32{data[31]}}, data[31:0]};
        else wd = data;
        check_value("dmem_req.addr", dmem_req.addr, addr);
      end
      7'b0100011: begin
        wen = 1'b0;
        is_st = 1'b1;
        mask = (f3 == 3'b000) ? 8'h01 : (f3 == 3'b010) ? 8'h0f : 8'hff;
        mask = mask << addr[2:0];
        data = rs2v << sh;
        for (int b = 0; b < 8; b++) begin
          lanes[8*b +: 8] = {8{mask[b]}};
        end
        check_value("dmem_req.addr", dmem_req.addr, addr);
        check_value("dmem_req.wmask", 64'(dmem_req.wmask), 64'(mask));
        check_value("dmem_req.wdata", dmem_req.wdata & lanes, data & lanes);
        m_mem[addr[10:3]] = (m_mem[addr[10:3]] & ~lanes) | (data & lanes);
      end
      7'b0010011: wd = rs1v + imm_i;
      default: begin
        case ({w[31:25], f3})
          10'b0000000_000: wd = rs1v + rs2v;
          10'b0100000_000: wd = rs1v - rs2v;
          10'b0000000_111: wd = rs1v & rs2v;
          10'b0000000_110: wd = rs1v | rs2v;
          10'b0000000_100: wd = rs1v ^ rs2v;
          default: wd = ($signed(rs1v) < $signed(rs2v)) ? 64'd1 : 64'd0;
        endcase
      end
    endcase
    check_value("dmem_req.ren", 64'(dmem_req.ren), 64'(is_ld));
    check_value("dmem_req.wen", 64'(dmem_req.wen), 64'(is_st));
    check_value("commit.rd", 64'(commit.rd), 64'(w[11:7]));
    check_value("commit.wen", 64'(commit.wen), 64'(wen));
    if (wen) begin
      check_value("commit.wdata", commit.wdata, wd);
      // x0 stays zero in the model too
      if (w[11:7] != 5'd0) m_regs[w[11:7]] = wd;
    end
    m_pc = npc;
  endtask

  // one program run from reset to halt or trap
  task automatic run_phase(input logic expect_trap);
    @(posedge clk) rst_n <= 1'b0;
    repeat (reset_cycles - 1) @(posedge clk);
    @(negedge clk);
    check_value("pc", pc, reset_pc);
    check_value("commit.valid", 64'(commit.valid), 64'd0);
    check_value("dmem_req.wen", 64'(dmem_req.wen), 64'd0);
    check_value("dmem_req.ren", 64'(dmem_req.ren), 64'd0);
    check_value("halted", 64'(halted), 64'd0);
    check_value("trapped", 64'(trapped), 64'd0);
    @(posedge clk) rst_n <= 1'b1;
    m_pc = reset_pc;
    @(negedge clk);
    while (!(halted || trapped)) begin
      if (commit.valid) model_retire();
      @(negedge clk);
    end
    check_value("halted", 64'(halted), 64'(!expect_trap));
    check_value("trapped", 64'(trapped), 64'(expect_trap));
    check_value("pc", pc, m_pc);
    check_value("inst", 64'(inst), expect_trap ? 64'(illegal_word) : 64'h0010_0073);
    // stopped core holds the pc of the stopping instruction
    repeat (freeze_cycles) begin
      @(negedge clk);
      check_value("commit.valid", 64'(commit.valid), 64'd0);
      check_value("pc", pc, m_pc);
      check_value("dmem_req.wen", 64'(dmem_req.wen), 64'd0);
      check_value("dmem_req.ren", 64'(dmem_req.ren), 64'd0);
    end
  endtask

  initial begin
    rst_n = 1'b0;
    errors = 0;
    checks = 0;
    lfsr_state = 32'he5e3;
    build_program();
    for (int i = 0; i < dmem_words; i++) begin
      m_mem[i] = fill_word(i);
    end
    for (int i = 0; i < 32; i++) begin
      m_regs[i] = '0;
    end
    run_phase(1'b0);
    // second run stops at an unknown encoding
    imem[illegal_slot] = illegal_word;
    run_phase(1'b1);
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// File: list.f
logic/core_cfg_pkg.sv
logic/rv_isa_pkg.sv
logic/inst_decoder.sv
logic/reg_file.sv
logic/alu.sv
logic/pc_unit.sv
logic/lsu.sv
logic/rv_core.sv
verification/core_checker.sv
verification/core_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = core_tb
FILELIST  = list.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then exit 1; fi
	@grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
